// File: include/ca_defs.svh
`ifndef CA_DEFS_SVH
`define CA_DEFS_SVH

// Bit range of a PRN number, 0 to 31 selects satellites 1 to 32
`define PRN_RANGE 4:0

// G1 and G2 shift registers, numbered 1 to 10 as in the ICD
`define G_RANGE 10:1

// Code shift counter, the chip index inside one code period
`define CS_RANGE 9:0

`define CA_CODE_LEN 1023

`endif

// File: src/ca_pkg.sv
`include "ca_defs.svh"

package ca_pkg;

   typedef enum logic {
      CMD_START = 1'b0,
      CMD_STOP  = 1'b1
   } cmd_op_e;

   typedef enum logic [1:0] {
      S_IDLE  = 2'd0,
      S_CMD   = 2'd1,
      S_SWEEP = 2'd2,
      S_DONE  = 2'd3
   } seq_state_e;

   // Both generators start from all ones at the code epoch
   localparam logic [`G_RANGE] G_INIT = 10'h3ff;

   typedef struct packed {
      logic [3:0] tap_a;
      logic [3:0] tap_b;
   } tap_pair_t;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // G2 phase selector taps per PRN
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   function automatic tap_pair_t prn_taps(input logic [`PRN_RANGE] prn);
      tap_pair_t t;
      case (prn)
         5'd0:  t = '{4'd2, 4'd6};
         5'd1:  t = '{4'd3, 4'd7};
         5'd2:  t = '{4'd4, 4'd8};
         5'd3:  t = '{4'd5, 4'd9};
         5'd4:  t = '{4'd1, 4'd9};
         5'd5:  t = '{4'd2, 4'd10};
         5'd6:  t = '{4'd1, 4'd8};
         5'd7:  t = '{4'd2, 4'd9};
         5'd8:  t = '{4'd3, 4'd10};
         5'd9:  t = '{4'd2, 4'd3};
         5'd10: t = '{4'd3, 4'd4};
         5'd11: t = '{4'd5, 4'd6};
         5'd12: t = '{4'd6, 4'd7};
         5'd13: t = '{4'd7, 4'd8};
         5'd14: t = '{4'd8, 4'd9};
         5'd15: t = '{4'd9, 4'd10};
         5'd16: t = '{4'd1, 4'd4};
         5'd17: t = '{4'd2, 4'd5};
         5'd18: t = '{4'd3, 4'd6};
         5'd19: t = '{4'd4, 4'd7};
         5'd20: t = '{4'd5, 4'd8};
         5'd21: t = '{4'd6, 4'd9};
         5'd22: t = '{4'd1, 4'd3};
         5'd23: t = '{4'd4, 4'd6};
         5'd24: t = '{4'd5, 4'd7};
         5'd25: t = '{4'd6, 4'd8};
         5'd26: t = '{4'd7, 4'd9};
         5'd27: t = '{4'd8, 4'd10};
         5'd28: t = '{4'd1, 4'd6};
         5'd29: t = '{4'd2, 4'd7};
         5'd30: t = '{4'd3, 4'd8};
         default: t = '{4'd4, 4'd9};
      endcase
      return t;
   endfunction

endpackage

// File: src/ca_state_if.sv
`include "ca_defs.svh"

interface ca_state_if #(
   parameter int NUM_CHAN = 4
);
   localparam int CHAN_W = $clog2(NUM_CHAN);

   logic [CHAN_W-1:0] chan;
   logic              wr;

   // Stored state of the selected channel
   logic [`G_RANGE]   g1;
   logic [`G_RANGE]   g2;
   logic [`CS_RANGE]  code_shift;
   logic [`PRN_RANGE] prn;
   logic              enable;

   // State one chip later
   logic [`G_RANGE]   g1_nxt;
   logic [`G_RANGE]   g2_nxt;
   logic [`CS_RANGE]  code_shift_nxt;

   modport mem (
      input  chan, wr, g1_nxt, g2_nxt, code_shift_nxt,
      output g1, g2, code_shift, prn, enable
   );

   modport step (
      input  g1, g2, code_shift, prn, enable,
      output g1_nxt, g2_nxt, code_shift_nxt
   );

   modport ctrl (
      output chan, wr
   );

endinterface

// File: src/ca_step.sv
`include "ca_defs.svh"

module ca_step (
   ca_state_if.step st,
   output logic     chip,
   output logic     epoch
);

   localparam int unsigned CS_LAST = `CA_CODE_LEN - 1;

   ca_pkg::tap_pair_t taps;
   logic              g1_fb;
   logic              g2_fb;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Shift register feedback
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // G1 is 1 + x^3 + x^10
   assign g1_fb = st.g1[3] ^ st.g1[10];

   // G2 is 1 + x^2 + x^3 + x^6 + x^8 + x^9 + x^10
   assign g2_fb = st.g2[2] ^ st.g2[3] ^ st.g2[6] ^ st.g2[8] ^ st.g2[9] ^ st.g2[10];

   always_comb begin
      if (st.enable) begin
         st.g1_nxt = {st.g1[9:1], g1_fb};
         st.g2_nxt = {st.g2[9:1], g2_fb};
         if (st.code_shift == CS_LAST[`CS_RANGE]) begin
            st.code_shift_nxt = '0;
         end else begin
            st.code_shift_nxt = st.code_shift + 1'b1;
         end
      end else begin
         // A stopped channel keeps its phase
         st.g1_nxt         = st.g1;
         st.g2_nxt         = st.g2;
         st.code_shift_nxt = st.code_shift;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Chip output
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   assign taps = ca_pkg::prn_taps(st.prn);

   // The two selected G2 stages form the delayed G2 sequence for this PRN
   assign chip = st.g1_nxt[10] ^ st.g2_nxt[taps.tap_a] ^ st.g2_nxt[taps.tap_b];

   assign epoch = st.enable && (st.code_shift_nxt == '0);

endmodule

// File: src/ca_state_mem.sv
`include "ca_defs.svh"

module ca_state_mem #(
   parameter int NUM_CHAN = 4
) (
   input logic        clk,
   input logic        rst_n,
   ca_state_if.mem    st,
   input logic        start,
   input logic        stop,
   input logic [`PRN_RANGE] prn_in
);

   localparam int CHAN_W = $clog2(NUM_CHAN);

   logic [`G_RANGE]   g1_q  [NUM_CHAN];
   logic [`G_RANGE]   g2_q  [NUM_CHAN];
   logic [`CS_RANGE]  cs_q  [NUM_CHAN];
   logic [`PRN_RANGE] prn_q [NUM_CHAN];
   logic [NUM_CHAN-1:0] en_q;
   logic [CHAN_W-1:0] sel;

   assign sel = st.chan;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         en_q <= '0;
         for (int i = 0; i < NUM_CHAN; i++) begin
            g1_q[i]  <= ca_pkg::G_INIT;
            g2_q[i]  <= ca_pkg::G_INIT;
            cs_q[i]  <= '0;
            prn_q[i] <= '0;
         end
      end else if (start) begin
         g1_q[sel]  <= ca_pkg::G_INIT;
         g2_q[sel]  <= ca_pkg::G_INIT;
         cs_q[sel]  <= '0;
         prn_q[sel] <= prn_in;
         en_q[sel]  <= 1'b1;
      end else if (stop) begin
         en_q[sel] <= 1'b0;
      end else if (st.wr) begin
         g1_q[sel] <= st.g1_nxt;
         g2_q[sel] <= st.g2_nxt;
         cs_q[sel] <= st.code_shift_nxt;
      end
   end

   // Read port follows the channel select
   assign st.g1         = g1_q[sel];
   assign st.g2         = g2_q[sel];
   assign st.code_shift = cs_q[sel];
   assign st.prn        = prn_q[sel];
   assign st.enable     = en_q[sel];

   a_start_stop_excl: assert property (@(posedge clk) disable iff (!rst_n)
      !(start && stop));

endmodule

// File: src/ca_sequencer.sv
`include "ca_defs.svh"

module ca_sequencer #(
   parameter int NUM_CHAN = 4,
   localparam int CHAN_W = $clog2(NUM_CHAN)
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              chip_tick,
   input  logic              cmd_valid,
   input  ca_pkg::cmd_op_e   cmd_op,
   input  logic [CHAN_W-1:0] cmd_chan,
   input  logic [`PRN_RANGE] cmd_prn,
   ca_state_if.ctrl          st,
   output logic              start,
   output logic              stop,
   output logic [`PRN_RANGE] prn_out,
   output logic              sample,
   output logic              publish,
   output logic              busy,
   output logic              done
);

   localparam logic [CHAN_W-1:0] LAST_CHAN = CHAN_W'(NUM_CHAN - 1);

   ca_pkg::seq_state_e state_q;
   logic [CHAN_W-1:0]  chan_q;
   ca_pkg::cmd_op_e    op_q;
   logic [CHAN_W-1:0]  cmd_chan_q;
   logic [`PRN_RANGE]  prn_q;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Control FSM
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= ca_pkg::S_IDLE;
         chan_q  <= '0;
         done    <= 1'b0;
      end else begin
         // done rises on the same edge that publishes the chips
         done <= (state_q == ca_pkg::S_DONE);
         case (state_q)
            ca_pkg::S_IDLE: begin
               // A command beats a tick in the same cycle
               if (cmd_valid) begin
                  state_q <= ca_pkg::S_CMD;
               end else if (chip_tick) begin
                  chan_q  <= '0;
                  state_q <= ca_pkg::S_SWEEP;
               end
            end
            ca_pkg::S_CMD: begin
               state_q <= ca_pkg::S_IDLE;
            end
            ca_pkg::S_SWEEP: begin
               if (chan_q == LAST_CHAN) begin
                  state_q <= ca_pkg::S_DONE;
               end else begin
                  chan_q <= chan_q + 1'b1;
               end
            end
            default: begin
               state_q <= ca_pkg::S_IDLE;
            end
         endcase
      end
   end

   // Command fields are only looked at in S_CMD
   always_ff @(posedge clk) begin
      if (state_q == ca_pkg::S_IDLE && cmd_valid) begin
         op_q       <= cmd_op;
         cmd_chan_q <= cmd_chan;
         prn_q      <= cmd_prn;
      end
   end

   assign st.chan = (state_q == ca_pkg::S_SWEEP) ? chan_q : cmd_chan_q;
   assign st.wr   = (state_q == ca_pkg::S_SWEEP);
   assign sample  = (state_q == ca_pkg::S_SWEEP);
   assign publish = (state_q == ca_pkg::S_DONE);
   assign busy    = (state_q != ca_pkg::S_IDLE);

   assign start   = (state_q == ca_pkg::S_CMD) && (op_q == ca_pkg::CMD_START);
   assign stop    = (state_q == ca_pkg::S_CMD) && (op_q == ca_pkg::CMD_STOP);
   assign prn_out = prn_q;

   a_done_single: assert property (@(posedge clk) disable iff (!rst_n)
      done |=> !done);

endmodule

// File: src/ca_chip_buffer.sv
module ca_chip_buffer #(
   parameter int NUM_CHAN = 4,
   localparam int CHAN_W = $clog2(NUM_CHAN)
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                sample,
   input  logic                publish,
   input  logic [CHAN_W-1:0]   chan,
   input  logic                chip,
   input  logic                epoch,
   output logic [NUM_CHAN-1:0] chips,
   output logic [NUM_CHAN-1:0] epochs
);

   logic [NUM_CHAN-1:0] chip_stage;
   logic [NUM_CHAN-1:0] epoch_stage;

   // Every channel is staged once per sweep before the publish cycle
   always_ff @(posedge clk) begin
      if (sample) begin
         chip_stage[chan]  <= chip;
         epoch_stage[chan] <= epoch;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         chips  <= '0;
         epochs <= '0;
      end else if (publish) begin
         chips  <= chip_stage;
         epochs <= epoch_stage;
      end
   end

endmodule

// File: src/ca_channel_bank.sv
`include "ca_defs.svh"

module ca_channel_bank #(
   parameter int NUM_CHAN = 4,
   localparam int CHAN_W = $clog2(NUM_CHAN)
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                chip_tick,
   input  logic                cmd_valid,
   input  ca_pkg::cmd_op_e     cmd_op,
   input  logic [CHAN_W-1:0]   cmd_chan,
   input  logic [`PRN_RANGE]   cmd_prn,
   output logic                busy,
   output logic                done,
   output logic [NUM_CHAN-1:0] chips,
   output logic [NUM_CHAN-1:0] epochs
);

   logic              start;
   logic              stop;
   logic [`PRN_RANGE] prn_cmd;
   logic              sample;
   logic              publish;
   logic              chip;
   logic              epoch;

   ca_state_if #(.NUM_CHAN(NUM_CHAN)) st ();

   ca_sequencer #(.NUM_CHAN(NUM_CHAN)) u_seq (
      .clk       (clk),
      .rst_n     (rst_n),
      .chip_tick (chip_tick),
      .cmd_valid (cmd_valid),
      .cmd_op    (cmd_op),
      .cmd_chan  (cmd_chan),
      .cmd_prn   (cmd_prn),
      .st        (st.ctrl),
      .start     (start),
      .stop      (stop),
      .prn_out   (prn_cmd),
      .sample    (sample),
      .publish   (publish),
      .busy      (busy),
      .done      (done)
   );

   ca_state_mem #(.NUM_CHAN(NUM_CHAN)) u_mem (
      .clk    (clk),
      .rst_n  (rst_n),
      .st     (st.mem),
      .start  (start),
      .stop   (stop),
      .prn_in (prn_cmd)
   );

   // One shared next-state block serves every channel in turn
   ca_step u_step (
      .st    (st.step),
      .chip  (chip),
      .epoch (epoch)
   );

   ca_chip_buffer #(.NUM_CHAN(NUM_CHAN)) u_buf (
      .clk     (clk),
      .rst_n   (rst_n),
      .sample  (sample),
      .publish (publish),
      .chan    (st.chan),
      .chip    (chip),
      .epoch   (epoch),
      .chips   (chips),
      .epochs  (epochs)
   );

endmodule

// File: tb/ca_ref_model.svh
`ifndef CA_REF_MODEL_SVH
`define CA_REF_MODEL_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference C/A generators, one set per channel
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// G2 phase selector stages for satellites 1 to 32, in PRN order
localparam int TAP_FIRST [32] = '{2, 3, 4, 5, 1, 2, 1, 2, 3, 2, 3, 5, 6, 7, 8, 9,
                                  1, 2, 3, 4, 5, 6, 1, 4, 5, 6, 7, 8, 1, 2, 3, 4};
localparam int TAP_SECOND [32] = '{6, 7, 8, 9, 9, 10, 8, 9, 10, 3, 4, 6, 7, 8, 9, 10,
                                   4, 5, 6, 7, 8, 9, 3, 6, 7, 8, 9, 10, 6, 7, 8, 9};

logic [10:1]         m_g1  [NUM_CHAN];
logic [10:1]         m_g2  [NUM_CHAN];
int                  m_cs  [NUM_CHAN];
logic [4:0]          m_prn [NUM_CHAN];
logic                m_en  [NUM_CHAN];
logic [NUM_CHAN-1:0] exp_chips;
logic [NUM_CHAN-1:0] exp_epochs;

task automatic model_reset();
   for (int c = 0; c < NUM_CHAN; c++) begin
      m_g1[c]  = 10'h3ff;
      m_g2[c]  = 10'h3ff;
      m_cs[c]  = 0;
      m_prn[c] = 5'd0;
      m_en[c]  = 1'b0;
   end
   exp_chips  = '0;
   exp_epochs = '0;
endtask

task automatic model_start(input int ch, input logic [4:0] prn);
   m_g1[ch]  = 10'h3ff;
   m_g2[ch]  = 10'h3ff;
   m_cs[ch]  = 0;
   m_prn[ch] = prn;
   m_en[ch]  = 1'b1;
endtask

task automatic model_stop(input int ch);
   m_en[ch] = 1'b0;
endtask

// One chip for every channel, the chip is taken from the advanced registers
task automatic model_tick();
   logic [10:1] g1;
   logic [10:1] g2;
   int          p;
   for (int c = 0; c < NUM_CHAN; c++) begin
      g1 = m_g1[c];
      g2 = m_g2[c];
      if (m_en[c]) begin
         g1 = {g1[9:1], g1[3] ^ g1[10]};
         g2 = {g2[9:1], g2[2] ^ g2[3] ^ g2[6] ^ g2[8] ^ g2[9] ^ g2[10]};
         m_cs[c] = (m_cs[c] + 1) % `CA_CODE_LEN;
      end
      m_g1[c] = g1;
      m_g2[c] = g2;
      p = m_prn[c];
      exp_chips[c]  = g1[10] ^ g2[TAP_FIRST[p]] ^ g2[TAP_SECOND[p]];
      exp_epochs[c] = m_en[c] && (m_cs[c] == 0);
   end
endtask

`endif

// File: tb/tb_ca_channel_bank.sv
`include "ca_defs.svh"

module tb_ca_channel_bank;

   localparam int NUM_CHAN = 4;
   localparam int CHAN_W   = $clog2(NUM_CHAN);

   localparam int TAP_TICKS     = 32 * 16;
   localparam int RUN_TICKS     = 100;
   localparam int RAND_ROUNDS   = 24;
   localparam int RAND_TICKS    = RAND_ROUNDS * 32;
   localparam int STOP_TICKS    = 8 + 20 + 8;
   localparam int WRAP_TICKS    = `CA_CODE_LEN + 16;
   localparam int BUSY_TICKS    = 4;
   localparam int PLANNED_TICKS = TAP_TICKS + RUN_TICKS + RAND_TICKS + STOP_TICKS
                                  + WRAP_TICKS + BUSY_TICKS;
   localparam int PLANNED_CMDS  = 32 + 3 + RAND_ROUNDS + 3 + 1 + 2;
   localparam int TIMEOUT_CYCLES = PLANNED_TICKS * (NUM_CHAN + 3) + PLANNED_CMDS * 3 + 1000;
   localparam int DONE_WAIT_MAX = 2 * NUM_CHAN + 8;

   logic                clk;
   logic                rst_n;
   logic                chip_tick;
   logic                cmd_valid;
   ca_pkg::cmd_op_e     cmd_op;
   logic [CHAN_W-1:0]   cmd_chan;
   logic [4:0]          cmd_prn;
   logic                busy;
   logic                done;
   logic [NUM_CHAN-1:0] chips;
   logic [NUM_CHAN-1:0] epochs;

   logic [31:0] rng;
   int unsigned cycle_count = 0;

   `include "ca_ref_model.svh"

   ca_channel_bank #(.NUM_CHAN(NUM_CHAN)) DUT (
      .clk       (clk),
      .rst_n     (rst_n),
      .chip_tick (chip_tick),
      .cmd_valid (cmd_valid),
      .cmd_op    (cmd_op),
      .cmd_chan  (cmd_chan),
      .cmd_prn   (cmd_prn),
      .busy      (busy),
      .done      (done),
      .chips     (chips),
      .epochs    (epochs)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count > TIMEOUT_CYCLES) begin
         stop_with_failure("Timeout: the test did not finish in the expected number of cycles");
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Helpers
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("RESULT: FAIL");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("** Error: %s = 0x%0h, expected 0x%0h", what, got, exp);
         stop_with_failure("Mismatch against the reference model");
      end
   endtask

   // Starts at a falling edge and returns at a falling edge with the DUT idle
   task automatic issue_command(input ca_pkg::cmd_op_e op, input logic [CHAN_W-1:0] ch,
                                input logic [4:0] prn, input logic with_tick);
      check("busy", busy, 1'b0);
      cmd_valid = 1'b1;
      cmd_op    = op;
      cmd_chan  = ch;
      cmd_prn   = prn;
      chip_tick = with_tick;
      @(negedge clk);
      cmd_valid = 1'b0;
      chip_tick = 1'b0;
      check("busy", busy, 1'b1);
      @(negedge clk);
      check("busy", busy, 1'b0);
      check("done", done, 1'b0);
      if (op == ca_pkg::CMD_START) begin
         model_start(ch, prn);
      end else begin
         model_stop(ch);
      end
      // The tick that lost against the command must never produce a sweep
      if (with_tick) begin
         repeat (NUM_CHAN + 2) begin
            @(negedge clk);
            check("done", done, 1'b0);
            check("chips", chips, exp_chips);
         end
      end
   endtask

   task automatic run_tick(input logic inject);
      int   n;
      logic got_done;
      check("busy", busy, 1'b0);
      chip_tick = 1'b1;
      n = 0;
      got_done = 1'b0;
      while (!got_done && n < DONE_WAIT_MAX) begin
         @(negedge clk);
         n++;
         if (inject && n <= NUM_CHAN) begin
            rng = xorshift32(rng);
            cmd_valid = 1'b1;
            chip_tick = 1'b1;
            cmd_op    = rng[0] ? ca_pkg::CMD_STOP : ca_pkg::CMD_START;
            cmd_chan  = rng[8 +: CHAN_W];
            cmd_prn   = rng[20:16];
         end else begin
            cmd_valid = 1'b0;
            chip_tick = 1'b0;
         end
         if (done) begin
            got_done = 1'b1;
         end else begin
            check("busy", busy, 1'b1);
            check("chips", chips, exp_chips);
            check("epochs", epochs, exp_epochs);
         end
      end
      if (!got_done) begin
         stop_with_failure("done did not arrive after an accepted chip tick");
      end else begin
         // Falling edge n lies half a cycle after rising edge n - 1 past the accept edge
         check("done latency in cycles", n - 1, NUM_CHAN + 1);
         model_tick();
         check("chips", chips, exp_chips);
         check("epochs", epochs, exp_epochs);
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Test sequence
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   initial begin
      int              n_ticks;
      ca_pkg::cmd_op_e op;
      logic [4:0]      prn;
      logic            held;
      logic            first_chips [8];
      logic            wrap_chips [16];

      rst_n     = 1'b0;
      chip_tick = 1'b0;
      cmd_valid = 1'b0;
      cmd_op    = ca_pkg::CMD_START;
      cmd_chan  = '0;
      cmd_prn   = '0;
      rng       = 32'h74485991;
      model_reset();

      repeat (5) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      check("busy", busy, 1'b0);
      check("done", done, 1'b0);
      check("chips", chips, '0);
      check("epochs", epochs, '0);

      // Every PRN on channel 0 to cover the whole tap table
      for (int p = 0; p < 32; p++) begin
         issue_command(ca_pkg::CMD_START, '0, p[4:0], 1'b0);
         repeat (16) run_tick(1'b0);
      end

      for (int c = 1; c < NUM_CHAN; c++) begin
         rng = xorshift32(rng);
         issue_command(ca_pkg::CMD_START, c[CHAN_W-1:0], rng[4:0], 1'b0);
      end
      repeat (RUN_TICKS) run_tick(1'b0);

      // Mostly starts, some stops, random tick runs
      for (int r = 0; r < RAND_ROUNDS; r++) begin
         rng = xorshift32(rng);
         op = (rng[2:0] == 3'd0) ? ca_pkg::CMD_STOP : ca_pkg::CMD_START;
         n_ticks = 1 + int'(rng[28:24]);
         issue_command(op, rng[8 +: CHAN_W], rng[20:16], rng[30]);
         repeat (n_ticks) run_tick(rng[31]);
      end

      // Stop freezes the chip and restart goes back to chip 0 of the code
      rng = xorshift32(rng);
      prn = rng[4:0];
      issue_command(ca_pkg::CMD_START, 2, prn, 1'b0);
      for (int i = 0; i < 8; i++) begin
         run_tick(1'b0);
         first_chips[i] = exp_chips[2];
      end
      held = exp_chips[2];
      issue_command(ca_pkg::CMD_STOP, 2, 5'd0, 1'b0);
      repeat (20) begin
         run_tick(1'b0);
         check("chips[2] while stopped", chips[2], held);
         check("epochs[2] while stopped", epochs[2], 1'b0);
      end
      issue_command(ca_pkg::CMD_START, 2, prn, 1'b0);
      for (int i = 0; i < 8; i++) begin
         run_tick(1'b0);
         check("chips[2] after restart", chips[2], first_chips[i]);
      end

      // Full code period on channel 3
      rng = xorshift32(rng);
      issue_command(ca_pkg::CMD_START, 3, rng[4:0], 1'b0);
      for (int k = 1; k <= WRAP_TICKS; k++) begin
         run_tick(1'b0);
         check("epochs[3]", epochs[3], k == `CA_CODE_LEN);
         if (k <= 16) begin
            wrap_chips[k-1] = exp_chips[3];
         end else if (k > `CA_CODE_LEN) begin
            check("chips[3] after wrap", chips[3], wrap_chips[k-`CA_CODE_LEN-1]);
         end
      end

      // Input while busy is dropped
      issue_command(ca_pkg::CMD_STOP, 1, 5'd0, 1'b1);
      repeat (BUSY_TICKS) run_tick(1'b1);
      rng = xorshift32(rng);
      issue_command(ca_pkg::CMD_START, 1, rng[4:0], 1'b1);

      $display("RESULT: PASS");
      $finish;
   end

endmodule

// File: build.f
+incdir+include
+incdir+tb
src/ca_pkg.sv
src/ca_state_if.sv
src/ca_step.sv
src/ca_state_mem.sv
src/ca_sequencer.sv
src/ca_chip_buffer.sv
src/ca_channel_bank.sv
tb/tb_ca_channel_bank.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_ca_channel_bank
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal
PASS_MSG  ?= RESULT: PASS

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard src/*.sv include/*.svh tb/*.sv tb/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
